//--- build.f
+incdir+common
common/testchip_pkg.sv
common/wb_pkg.sv
sram/sram_1rw1r.sv
scan/scan_chain.sv
src/dout_capture.sv
src/test_ctrl.sv
src/testchip_top.sv
verif/tb_testchip.sv

//--- common/testchip_params.svh
/* sizes shared by the packages and the RTL
   macro 0 decodes only the low TC_M0_ADDR_W address bits
   the scan word must hold one full dout pair */
`ifndef TESTCHIP_PARAMS_SVH
`define TESTCHIP_PARAMS_SVH

// data path
`define TC_DATA_W       32
`define TC_WMASK_W      4

// shared address bus, sized for the larger macro
`define TC_ADDR_W       9
`define TC_M0_ADDR_W    8

`define TC_NUM_MACROS   2

// serial access
`define TC_SCAN_W       64

// wishbone byte address bit picking macro 1
`define TC_WB_MACRO_BIT 11

`endif

//--- common/testchip_pkg.sv
/* memory-side types for the SRAM test harness
   scan_cmd_t and dout_pair_t are both exactly TC_SCAN_W bits wide
   chip selects and web0 are active low */
`include "testchip_params.svh"

package testchip_pkg;

   // shared bus to every macro, only csb is per macro
   typedef struct packed {
      logic                   web0;
      logic [`TC_WMASK_W-1:0] wmask0;
      logic [`TC_ADDR_W-1:0]  addr0;
      logic [`TC_DATA_W-1:0]  din0;
      logic [`TC_ADDR_W-1:0]  addr1;
   } mem_req_t;

   // one bit per macro, low selects
   typedef logic [`TC_NUM_MACROS-1:0] csb_vec_t;

   // port 0 in the upper half
   typedef struct packed {
      logic [`TC_DATA_W-1:0] dout0;
      logic [`TC_DATA_W-1:0] dout1;
   } dout_pair_t;

   // command layout, msb first
   typedef struct packed {
      logic                   macro_sel;
      logic                   csb0;
      logic                   web0;
      logic [`TC_WMASK_W-1:0] wmask0;
      logic [`TC_ADDR_W-1:0]  addr0;
      logic [`TC_DATA_W-1:0]  din0;
      logic                   csb1;
      logic [`TC_ADDR_W-1:0]  addr1;
      logic [5:0]             spare;
   } scan_cmd_t;

   // same chain bits, command going in and results coming out
   typedef union packed {
      scan_cmd_t  cmd;
      dout_pair_t res;
   } scan_word_u;

endpackage

//--- common/wb_pkg.sv
/* wishbone classic single-access signals
   no stall, err or burst tags are carried */
`include "testchip_params.svh"

package wb_pkg;

   typedef struct packed {
      logic                   cyc;
      logic                   stb;
      logic                   we;
      logic [`TC_WMASK_W-1:0] sel;
      logic [31:0]            adr;
      logic [`TC_DATA_W-1:0]  dat;
   } wb_req_t;

   typedef struct packed {
      logic                  ack;
      logic [`TC_DATA_W-1:0] dat;
   } wb_rsp_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# compile and run the testchip testbench with verilator
# the run fails when the log holds the fail message or the build breaks
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_testchip \
   -Mdir obj_dir -f build.f > build.log 2>&1 \
   || { echo "compile failed, see build.log"; exit 1; }

./obj_dir/Vtb_testchip > sim.log 2>&1
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"

//--- scan/scan_chain.sv
/* serial access register, shifted msb first
   bit 0 takes the serial input, bit TC_SCAN_W-1 drives the output
   a result load wins over a shift in the same cycle */
`timescale 1ns/10ps
`include "testchip_params.svh"

module scan_chain
   import testchip_pkg::*;
(
   input  logic       clk,
   input  logic       rstn,
   input  logic       scan_en_i,
   input  logic       scan_in_i,
   input  logic       load_i,
   input  dout_pair_t result_i,
   output scan_word_u word_o,
   output logic       scan_out_o
);

   scan_word_u word_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         word_q <= '0;
      end else if (load_i) begin
         // result view overwrites the whole word
         word_q.res <= result_i;
      end else if (scan_en_i) begin
         word_q <= {word_q[`TC_SCAN_W-2:0], scan_in_i};
      end
   end

   // controller decodes the command view
   assign word_o = word_q;

   // msb leaves first
   assign scan_out_o = word_q[`TC_SCAN_W-1];

endmodule

//--- sram/sram_1rw1r.sv
/* behavioral 1rw1r macro, 2**ADDR_W words, contents not reset
   upper address bits beyond ADDR_W are ignored, so addresses alias
   port 1 reads old data on a same-cycle write to the same word */
`timescale 1ns/10ps
`include "testchip_params.svh"

module sram_1rw1r #(
   parameter int ADDR_W = 8
) (
   input  logic                   clk,
   input  logic                   csb0_i,
   input  logic                   web0_i,
   input  logic [`TC_WMASK_W-1:0] wmask0_i,
   input  logic [`TC_ADDR_W-1:0]  addr0_i,
   input  logic [`TC_DATA_W-1:0]  din0_i,
   input  logic                   csb1_i,
   input  logic [`TC_ADDR_W-1:0]  addr1_i,
   output logic [`TC_DATA_W-1:0]  dout0_o,
   output logic [`TC_DATA_W-1:0]  dout1_o
);

   localparam int BYTE_W = `TC_DATA_W / `TC_WMASK_W;

   logic [`TC_DATA_W-1:0] mem [2**ADDR_W];
   logic [ADDR_W-1:0]     a0;
   logic [ADDR_W-1:0]     a1;

   // low bits only
   assign a0 = addr0_i[ADDR_W-1:0];
   assign a1 = addr1_i[ADDR_W-1:0];

   // port 0, read or masked write
   always_ff @(posedge clk) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            // dout0 keeps its last read on a write
            for (int i = 0; i < `TC_WMASK_W; i++) begin
               if (wmask0_i[i]) begin
                  mem[a0][i*BYTE_W +: BYTE_W] <= din0_i[i*BYTE_W +: BYTE_W];
               end
            end
         end else begin
            dout0_o <= mem[a0];
         end
      end
   end

   // port 1, read only
   always_ff @(posedge clk) begin
      if (!csb1_i) begin
         dout1_o <= mem[a1];
      end
   end

endmodule

//--- src/dout_capture.sv
/* samples both macros' outputs on every clock
   selected pair lags the macro pins by one cycle */
`timescale 1ns/10ps

module dout_capture
   import testchip_pkg::*;
(
   input  logic       clk,
   input  logic       rstn,
   input  dout_pair_t m0_i,
   input  dout_pair_t m1_i,
   input  logic       sel_i,
   output dout_pair_t dout_o
);

   dout_pair_t m0_q;
   dout_pair_t m1_q;

   // free running, no enable
   always_ff @(posedge clk) begin
      if (!rstn) begin
         m0_q <= '0;
         m1_q <= '0;
      end else begin
         m0_q <= m0_i;
         m1_q <= m1_i;
      end
   end

   // sel comes from a register, mux stays glitch free per cycle
   always_comb begin
      if (sel_i) begin
         dout_o = m1_q;
      end else begin
         dout_o = m0_q;
      end
   end

endmodule

//--- src/test_ctrl.sv
/* access sequencer for scan loads and wishbone single accesses
   access in the start cycle, result or ack two cycles later
   a new start is taken only from idle, so starts are 3+ cycles apart */
`timescale 1ns/10ps
`include "testchip_params.svh"

module test_ctrl
   import testchip_pkg::*;
   import wb_pkg::*;
(
   input  logic       clk,
   input  logic       rstn,
   input  logic       wb_mode_i,
   input  logic       gpio_load_i,
   input  logic       global_csb_i,
   input  scan_word_u scan_word_i,
   input  wb_req_t    wb_req_i,
   input  dout_pair_t cap_dout_i,
   output mem_req_t   mem_req_o,
   output csb_vec_t   csb0_o,
   output csb_vec_t   csb1_o,
   output logic       cap_sel_o,
   output logic       load_result_o,
   output wb_rsp_t    wb_rsp_o
);

   // access is transient, only seen in the start cycle
   typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_WAIT, ST_FINISH} state_e;

   state_e    state_q;
   state_e    state_cur;
   state_e    state_d;
   scan_cmd_t cmd;
   logic      gpio_start;
   logic      wb_start;
   logic      macro_sel;
   logic      port0_req;
   logic      port1_req;
   logic      access;
   logic      is_wb_q;
   logic      finish;

   assign cmd = scan_word_i.cmd;

   // each mode ignores the other's trigger
   assign gpio_start = !wb_mode_i && gpio_load_i;
   assign wb_start   = wb_mode_i && wb_req_i.cyc && wb_req_i.stb;

   always_comb begin
      state_cur = state_q;
      if (state_q == ST_IDLE && (gpio_start || wb_start)) begin
         state_cur = ST_ACCESS;
      end
   end

   // access -> dout on macro pins -> captured pair valid
   always_comb begin
      case (state_cur)
         ST_ACCESS: state_d = ST_WAIT;
         ST_WAIT:   state_d = ST_FINISH;
         default:   state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state_q   <= ST_IDLE;
         is_wb_q   <= 1'b0;
         cap_sel_o <= 1'b0;
      end else begin
         state_q <= state_d;
         // remember source and macro until finish
         if (state_cur == ST_ACCESS) begin
            is_wb_q   <= wb_mode_i;
            cap_sel_o <= macro_sel;
         end
      end
   end

   // shared bus follows the active mode every cycle
   always_comb begin
      if (wb_mode_i) begin
         mem_req_o.web0   = !wb_req_i.we;
         mem_req_o.wmask0 = wb_req_i.sel;
         // word index from byte address
         mem_req_o.addr0  = wb_req_i.adr[`TC_ADDR_W+1:2];
         mem_req_o.din0   = wb_req_i.dat;
         mem_req_o.addr1  = wb_req_i.adr[`TC_ADDR_W+1:2];
         macro_sel        = wb_req_i.adr[`TC_WB_MACRO_BIT];
         // wishbone uses port 0 only
         port0_req        = 1'b1;
         port1_req        = 1'b0;
      end else begin
         mem_req_o.web0   = cmd.web0;
         mem_req_o.wmask0 = cmd.wmask0;
         mem_req_o.addr0  = cmd.addr0;
         mem_req_o.din0   = cmd.din0;
         mem_req_o.addr1  = cmd.addr1;
         macro_sel        = cmd.macro_sel;
         port0_req        = !cmd.csb0;
         port1_req        = !cmd.csb1;
      end
   end

   // global csb blocks every select
   assign access = (state_cur == ST_ACCESS) && !global_csb_i;

   always_comb begin
      for (int m = 0; m < `TC_NUM_MACROS; m++) begin
         csb0_o[m] = !(access && port0_req && (macro_sel == m));
         csb1_o[m] = !(access && port1_req && (macro_sel == m));
      end
   end

   assign finish        = (state_q == ST_FINISH);
   assign load_result_o = finish && !is_wb_q;
   assign wb_rsp_o.ack  = finish && is_wb_q;
   // dout0 of the captured pair, zero outside ack
   assign wb_rsp_o.dat  = wb_rsp_o.ack ? cap_dout_i.dout0 : '0;

endmodule

//--- src/testchip_top.sv
/* SRAM test harness top, single clk and synchronous rstn
   wb_mode_i must be stable while an access is in flight
   scan and load pulses must not overlap */
`timescale 1ns/10ps
`include "testchip_params.svh"

module testchip_top
   import testchip_pkg::*;
   import wb_pkg::*;
(
   input  logic    clk,
   input  logic    rstn,
   input  logic    wb_mode_i,
   input  logic    gpio_scan_i,
   input  logic    gpio_load_i,
   input  logic    gpio_in_i,
   input  logic    global_csb_i,
   input  wb_req_t wb_req_i,
   output logic    gpio_out_o,
   output wb_rsp_t wb_rsp_o
);

   mem_req_t   mem_req;
   csb_vec_t   csb0;
   csb_vec_t   csb1;
   logic       cap_sel;
   logic       load_result;
   scan_word_u scan_word;
   dout_pair_t cap_dout;
   // raw macro outputs, before capture
   dout_pair_t m0_dout;
   dout_pair_t m1_dout;

   test_ctrl u_ctrl (
      .clk           (clk),
      .rstn          (rstn),
      .wb_mode_i     (wb_mode_i),
      .gpio_load_i   (gpio_load_i),
      .global_csb_i  (global_csb_i),
      .scan_word_i   (scan_word),
      .wb_req_i      (wb_req_i),
      .cap_dout_i    (cap_dout),
      .mem_req_o     (mem_req),
      .csb0_o        (csb0),
      .csb1_o        (csb1),
      .cap_sel_o     (cap_sel),
      .load_result_o (load_result),
      .wb_rsp_o      (wb_rsp_o)
   );

   scan_chain u_scan (
      .clk        (clk),
      .rstn       (rstn),
      .scan_en_i  (gpio_scan_i),
      .scan_in_i  (gpio_in_i),
      .load_i     (load_result),
      .result_i   (cap_dout),
      .word_o     (scan_word),
      .scan_out_o (gpio_out_o)
   );

   // macro 0, 32x256
   sram_1rw1r #(.ADDR_W(`TC_M0_ADDR_W)) u_sram0 (
      .clk      (clk),
      .csb0_i   (csb0[0]),
      .web0_i   (mem_req.web0),
      .wmask0_i (mem_req.wmask0),
      .addr0_i  (mem_req.addr0),
      .din0_i   (mem_req.din0),
      .csb1_i   (csb1[0]),
      .addr1_i  (mem_req.addr1),
      .dout0_o  (m0_dout.dout0),
      .dout1_o  (m0_dout.dout1)
   );

   // macro 1, 32x512
   sram_1rw1r #(.ADDR_W(`TC_ADDR_W)) u_sram1 (
      .clk      (clk),
      .csb0_i   (csb0[1]),
      .web0_i   (mem_req.web0),
      .wmask0_i (mem_req.wmask0),
      .addr0_i  (mem_req.addr0),
      .din0_i   (mem_req.din0),
      .csb1_i   (csb1[1]),
      .addr1_i  (mem_req.addr1),
      .dout0_o  (m1_dout.dout0),
      .dout1_o  (m1_dout.dout1)
   );

   dout_capture u_cap (
      .clk    (clk),
      .rstn   (rstn),
      .m0_i   (m0_dout),
      .m1_i   (m1_dout),
      .sel_i  (cap_sel),
      .dout_o (cap_dout)
   );

endmodule

//--- verif/tb_testchip.sv
/* testbench for the SRAM test harness against a local memory model
   memory is not reset so only words written earlier are read back
   stops at the first mismatch */
`timescale 1ns/10ps
`include "testchip_params.svh"

module tb_testchip
   import wb_pkg::*;
;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYC    = 8;
   // shift in, load to result, shift out
   localparam int SCAN_ACC_CYC = 2 * `TC_SCAN_W + 3;
   localparam int NUM_SCAN_ACC = 10;
   localparam int WB_ACC_CYC   = 4;
   localparam int NUM_WB_ACC   = 20;
   localparam int TOTAL_CYC    = RESET_CYC + `TC_SCAN_W + NUM_SCAN_ACC * SCAN_ACC_CYC
                                 + NUM_WB_ACC * WB_ACC_CYC + 200;

   logic        clk;
   logic        rstn;
   logic        wb_mode;
   logic        gpio_scan;
   logic        gpio_load;
   logic        gpio_in;
   logic        global_csb;
   logic        gpio_out;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   // key is macro * 1024 + decoded word
   logic [31:0] model [int];
   string       test_name;

   testchip_top UUT (
      .clk          (clk),
      .rstn         (rstn),
      .wb_mode_i    (wb_mode),
      .gpio_scan_i  (gpio_scan),
      .gpio_load_i  (gpio_load),
      .gpio_in_i    (gpio_in),
      .global_csb_i (global_csb),
      .wb_req_i     (wb_req),
      .gpio_out_o   (gpio_out),
      .wb_rsp_o     (wb_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic report_mismatch(input logic [63:0] exp, input logic [63:0] act);
      $display("** Error %s: expected %h, actual %h", test_name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic check_value(input logic [63:0] exp, input logic [63:0] act);
      assert (act === exp) else report_mismatch(exp, act);
   endtask

   // ack is a single-cycle pulse and stays low in gpio mode
   ack_single: assert property (@(posedge clk) disable iff (!rstn) wb_rsp.ack |=> !wb_rsp.ack)
      else report_mismatch(64'h0, 64'h1);
   ack_gpio: assert property (@(posedge clk) disable iff (!rstn) !wb_mode |-> !wb_rsp.ack)
      else report_mismatch(64'h0, 64'h1);

   // macro 0 drops the top address bit
   function automatic int model_key(input logic macro, input logic [8:0] addr);
      if (macro) begin
         return 1024 + int'(addr);
      end
      return int'(addr[7:0]);
   endfunction

   function automatic void model_write(input logic macro, input logic [8:0] addr,
                                       input logic [31:0] data, input logic [3:0] mask);
      logic [31:0] word;
      int          key;
      key  = model_key(macro, addr);
      word = model.exists(key) ? model[key] : 32'h0;
      for (int i = 0; i < 4; i++) begin
         if (mask[i]) begin
            word[i*8 +: 8] = data[i*8 +: 8];
         end
      end
      model[key] = word;
   endfunction

   function automatic logic [31:0] model_read(input logic macro, input logic [8:0] addr);
      return model[model_key(macro, addr)];
   endfunction

   // scan command msb first with six spare bits at the bottom
   function automatic logic [63:0] make_cmd(input logic macro, input logic csb0,
         input logic web0, input logic [3:0] wmask, input logic [8:0] addr0,
         input logic [31:0] din0, input logic csb1, input logic [8:0] addr1);
      return {macro, csb0, web0, wmask, addr0, din0, csb1, addr1, 6'h0};
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic scan_shift(input logic [63:0] din, output logic [63:0] dout);
      for (int i = `TC_SCAN_W - 1; i >= 0; i--) begin
         gpio_scan = 1'b1;
         gpio_in   = din[i];
         // msb shows before each shift
         dout[i]   = gpio_out;
         next_cycle();
      end
      gpio_scan = 1'b0;
      gpio_in   = 1'b0;
   endtask

   // load in L and result lands in the chain at the end of L+2
   task automatic pulse_load();
      gpio_load = 1'b1;
      #1;
      if (global_csb) begin
         check_value(64'h3, {62'h0, UUT.csb0 & UUT.csb1});
      end
      next_cycle();
      gpio_load = 1'b0;
      check_value(64'h0, {63'h0, UUT.load_result});
      next_cycle();
      check_value(64'h1, {63'h0, UUT.load_result});
      next_cycle();
   endtask

   task automatic scan_access(input logic [63:0] cmd, output logic [63:0] res);
      logic [63:0] unused;
      scan_shift(cmd, unused);
      pulse_load();
      scan_shift(64'h0, res);
   endtask

   task automatic scan_write(input logic macro, input logic [8:0] addr,
                             input logic [31:0] data, input logic [3:0] mask);
      logic [63:0] res;
      scan_access(make_cmd(macro, 1'b0, 1'b0, mask, addr, data, 1'b1, 9'h0), res);
      model_write(macro, addr, data, mask);
   endtask

   // dout0 sits in the upper half of the result
   task automatic scan_read(input logic macro, input logic [8:0] addr);
      logic [63:0] res;
      scan_access(make_cmd(macro, 1'b0, 1'b1, 4'hf, addr, 32'h0, 1'b1, 9'h0), res);
      check_value({32'h0, model_read(macro, addr)}, {32'h0, res[63:32]});
   endtask

   task automatic wb_access(input logic we, input logic macro, input logic [8:0] word,
                            input logic [31:0] data, input logic [3:0] sel,
                            output logic [31:0] rdata);
      int wait_cyc;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.sel = sel;
      wb_req.adr = ({31'h0, macro} << `TC_WB_MACRO_BIT) | ({23'h0, word} << 2);
      wb_req.dat = data;
      wait_cyc   = 0;
      while (!wb_rsp.ack && wait_cyc < 8) begin
         next_cycle();
         wait_cyc++;
      end
      // ack due in A+2
      check_value(64'd2, 64'(wait_cyc));
      rdata      = wb_rsp.dat;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      next_cycle();
      check_value(64'h0, {63'h0, wb_rsp.ack});
   endtask

   task automatic wb_write(input logic macro, input logic [8:0] word,
                           input logic [31:0] data, input logic [3:0] sel);
      logic [31:0] unused;
      wb_access(1'b1, macro, word, data, sel, unused);
      model_write(macro, word, data, sel);
   endtask

   task automatic wb_read(input logic macro, input logic [8:0] word);
      logic [31:0] rdata;
      wb_access(1'b0, macro, word, 32'h0, 4'hf, rdata);
      check_value({32'h0, model_read(macro, word)}, {32'h0, rdata});
   endtask

   initial begin
      #(TOTAL_CYC * CLK_PERIOD);
      $display("timeout: tests did not finish within %0d cycles", TOTAL_CYC);
      $display("=== FAIL ===");
      $fatal(1, "watchdog expired");
   end

   initial begin
      logic [63:0] res;
      logic [8:0]  addr [2];
      logic [8:0]  word;
      logic [31:0] data;
      logic [31:0] old;
      logic        macro;
      void'($urandom(32'h6e22));
      test_name  = "reset";
      rstn       = 1'b0;
      wb_mode    = 1'b0;
      gpio_scan  = 1'b0;
      gpio_load  = 1'b0;
      gpio_in    = 1'b0;
      global_csb = 1'b0;
      wb_req     = '0;
      repeat (RESET_CYC) @(posedge clk);
      #2;
      rstn = 1'b1;

      check_value(64'h0, {63'h0, wb_rsp.ack});
      check_value(64'h0, {63'h0, gpio_out});
      check_value(64'h3, {62'h0, UUT.csb0 & UUT.csb1});
      scan_shift(64'h0, res);
      check_value(64'h0, res);

      test_name = "scan_write_read";
      for (int m = 0; m < 2; m++) begin
         addr[m] = 9'($urandom);
         scan_write(m[0], addr[m], $urandom, 4'hf);
         scan_read(m[0], addr[m]);
      end

      // port 1 reads before the port 0 write lands
      test_name = "port1_old_data";
      old  = model_read(1'b1, addr[1]);
      word = addr[1] ^ 9'h1;
      data = $urandom;
      scan_access(make_cmd(1'b1, 1'b0, 1'b0, 4'hf, word, data, 1'b0, addr[1]), res);
      check_value({32'h0, old}, {32'h0, res[31:0]});
      model_write(1'b1, word, data, 4'hf);
      scan_read(1'b1, word);
      test_name = "same_addr_collision";
      old  = model_read(1'b0, addr[0]);
      data = $urandom;
      scan_access(make_cmd(1'b0, 1'b0, 1'b0, 4'hf, addr[0], data, 1'b0, addr[0]), res);
      check_value({32'h0, old}, {32'h0, res[31:0]});
      model_write(1'b0, addr[0], data, 4'hf);
      scan_read(1'b0, addr[0]);

      test_name = "wb_byte_merge";
      wb_mode   = 1'b1;
      next_cycle();
      for (int r = 0; r < 4; r++) begin
         macro = 1'($urandom);
         word  = 9'($urandom);
         wb_write(macro, word, $urandom, 4'hf);
         wb_write(macro, word, $urandom, 4'($urandom));
         wb_read(macro, word);
      end

      test_name = "macro_separation";
      word = {1'b0, 8'($urandom)};
      wb_write(1'b0, word, $urandom, 4'hf);
      wb_write(1'b1, word, $urandom, 4'hf);
      wb_read(1'b0, word);
      wb_read(1'b1, word);
      // top bit is ignored by macro 0
      test_name = "m0_alias";
      wb_read(1'b0, word | 9'h100);
      wb_write(1'b0, word | 9'h100, $urandom, 4'hf);
      wb_read(1'b0, word);
      wb_read(1'b1, word);

      test_name = "global_csb";
      wb_mode   = 1'b0;
      next_cycle();
      global_csb = 1'b1;
      data = ~model_read(1'b0, addr[0]);
      scan_access(make_cmd(1'b0, 1'b0, 1'b0, 4'hf, addr[0], data, 1'b1, 9'h0), res);
      global_csb = 1'b0;
      scan_read(1'b0, addr[0]);

      $display("=== PASS ===");
      $finish;
   end

endmodule
